/* common/seq_pkg.sv */
// Program sequencer definitions
package seq_pkg;

	// Widths
	localparam int data_w = 16;
	localparam int inst_w = 32;
	localparam int flag_w = 8;
	localparam int astat_w = 10;
	localparam int rf_addr_w = 4;
	localparam int sreg_addr_w = 5;
	localparam int ureg_w = 8;
	localparam int cc_w = 5;

	// Instruction word fields
	localparam int cond_en_bit = 31;
	localparam int compute_bit = 30;
	localparam int class_hi = 29;
	localparam int class_lo = 24;
	localparam int dst_lo = 16;
	localparam int src_lo = 8;
	localparam int imm_lo = 0;
	localparam int cc_lo = 0;
	localparam int cu_hi = 25;
	localparam int cu_lo = 5;
	localparam int cu_w = cu_hi - cu_lo + 1;
	localparam int isel_lo = 10;
	localparam int msel_lo = 7;
	localparam int dm_wr_bit = 6;

	// Class codes, compared against the upper class bits
	localparam logic [5:0] cls_push = 6'b000010;
	localparam logic [5:0] cls_pop = 6'b000011;
	localparam logic [3:0] cls_imm = 4'b0011;
	localparam logic [3:0] cls_dm = 4'b1001;
	localparam logic [3:0] cls_utrans = 4'b0001;
	localparam logic [8:0] idle_code = 9'd1;

	// Ureg groups
	localparam logic [2:0] grp_rf = 3'd0;
	localparam logic [2:0] grp_dag = 3'd1;
	localparam logic [2:0] grp_seq = 3'd2;

	// Sequencer register addresses
	localparam logic [sreg_addr_w-1:0] sr_faddr = 5'd0;
	localparam logic [sreg_addr_w-1:0] sr_daddr = 5'd1;
	localparam logic [sreg_addr_w-1:0] sr_pc = 5'd3;
	localparam logic [sreg_addr_w-1:0] sr_pcstk = 5'd4;
	localparam logic [sreg_addr_w-1:0] sr_pcstkp = 5'd5;
	localparam logic [sreg_addr_w-1:0] sr_mode1 = 5'd27;
	localparam logic [sreg_addr_w-1:0] sr_astat = 5'd28;
	localparam logic [sreg_addr_w-1:0] sr_sticky = 5'd30;

endpackage

/* sequencer/seq_ctrl.sv */
// Sequencer fetch and instruction control
`timescale 1ns/1ps

module seq_ctrl #(
	parameter logic [seq_pkg::data_w-1:0] reset_addr = '0
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            interrupt,
	input  logic [seq_pkg::inst_w-1:0]      inst,
	input  logic                            cond_true,
	input  logic [seq_pkg::rf_addr_w-1:0]   cu_raddr_x,
	input  logic [seq_pkg::rf_addr_w-1:0]   xfer_raddr,
	input  logic [seq_pkg::rf_addr_w-1:0]   cu_waddr,
	input  logic [seq_pkg::rf_addr_w-1:0]   xfer_waddr,
	output logic [seq_pkg::data_w-1:0]      pm_addr,
	output logic                            pm_cs,
	output logic                            dm_cs,
	output logic                            dm_wrb,
	output logic                            dag_en,
	output logic                            dag_modify,
	output logic [2:0]                      dag_isel,
	output logic [2:0]                      dag_msel,
	output logic [seq_pkg::data_w-1:0]      imm_data,
	output logic [seq_pkg::rf_addr_w-1:0]   rf_raddr_x,
	output logic [seq_pkg::rf_addr_w-1:0]   rf_waddr,
	output logic                            cond_en,
	output logic [seq_pkg::cc_w-1:0]        cond_code,
	output logic                            cu_en,
	output logic [seq_pkg::cu_w-1:0]        cu_field,
	output logic                            push,
	output logic                            pop,
	output logic                            imm_inst,
	output logic                            dm_inst,
	output logic                            utrans_inst,
	output logic [seq_pkg::ureg_w-1:0]      ureg_dst,
	output logic [seq_pkg::ureg_w-1:0]      ureg_src,
	output logic [seq_pkg::data_w-1:0]      faddr_q,
	output logic [seq_pkg::data_w-1:0]      daddr_q,
	output logic [seq_pkg::data_w-1:0]      pc_q
);
	import seq_pkg::*;

	logic idle_q;
	logic run;
	logic non_cu;
	logic cu_sel_q;
	logic [rf_addr_w-1:0] xfer_waddr_q;
	logic [data_w-1:0] imm_q;

	// Three stage address pipeline, frozen while idle
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			faddr_q <= reset_addr;
			daddr_q <= reset_addr;
			pc_q <= reset_addr;
		end else if (!idle_q) begin
			faddr_q <= faddr_q + data_w'(1);
			daddr_q <= faddr_q;
			pc_q <= daddr_q;
		end
	end

	// Idle holds until an interrupt is seen
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			idle_q <= 1'b0;
		end else if (idle_q) begin
			idle_q <= !interrupt;
		end else begin
			idle_q <= (inst[inst_w-1 -: 9] == idle_code);
		end
	end

	assign pm_addr = faddr_q;
	assign pm_cs = !idle_q;

	assign cond_en = inst[cond_en_bit];
	assign cond_code = inst[cc_lo +: cc_w];

	// Class strobes
	assign run = cond_true && !idle_q;
	assign non_cu = !inst[compute_bit] && run;
	assign push = non_cu && (inst[class_hi:class_lo] == cls_push);
	assign pop = non_cu && (inst[class_hi:class_lo] == cls_pop);
	assign imm_inst = non_cu && (inst[class_hi -: 4] == cls_imm);
	assign dm_inst = non_cu && (inst[class_hi -: 4] == cls_dm);
	assign utrans_inst = non_cu && (inst[class_hi -: 4] == cls_utrans);

	assign cu_en = inst[compute_bit] && run;
	assign cu_field = inst[cu_hi:cu_lo];
	assign ureg_dst = inst[dst_lo +: ureg_w];
	assign ureg_src = inst[src_lo +: ureg_w];

	// Data memory and DAG controls
	assign dm_cs = dm_inst;
	assign dm_wrb = inst[dm_wr_bit];
	assign dag_en = non_cu && inst[class_hi];
	assign dag_modify = inst[class_hi-1];
	assign dag_isel = inst[isel_lo +: 3];
	assign dag_msel = inst[msel_lo +: 3];

	// Immediate stays on the bus after the word has passed
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			imm_q <= '0;
		end else if (imm_inst) begin
			imm_q <= inst[imm_lo +: data_w];
		end
	end

	assign imm_data = imm_inst ? inst[imm_lo +: data_w] : imm_q;

	// Register file address muxing
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cu_sel_q <= 1'b0;
			xfer_waddr_q <= '0;
		end else begin
			cu_sel_q <= cu_en;
			xfer_waddr_q <= xfer_waddr;
		end
	end

	assign rf_raddr_x = cu_en ? cu_raddr_x : xfer_raddr;
	// cu_waddr is already one cycle late from the compute decoder
	assign rf_waddr = cu_sel_q ? cu_waddr : xfer_waddr_q;

endmodule

/* sequencer/seq_regs.sv */
// Sequencer registers and readback
`timescale 1ns/1ps

module seq_regs #(
	parameter int stack_depth = 2
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              push,
	input  logic                              pop,
	input  logic [seq_pkg::data_w-1:0]        faddr_q,
	input  logic [seq_pkg::data_w-1:0]        daddr_q,
	input  logic [seq_pkg::data_w-1:0]        pc_q,
	input  logic [seq_pkg::sreg_addr_w-1:0]   seq_rd_addr,
	input  logic [seq_pkg::sreg_addr_w-1:0]   seq_wr_addr,
	input  logic                              seq_wen,
	input  logic [seq_pkg::data_w-1:0]        bc_data,
	input  logic [seq_pkg::astat_w-1:0]       status,
	output logic [seq_pkg::flag_w-1:0]        flags,
	output logic [seq_pkg::data_w-1:0]        seq_rd_data
);
	import seq_pkg::*;

	localparam int idx_w = (stack_depth > 1) ? $clog2(stack_depth) : 1;
	localparam int cnt_w = $clog2(stack_depth + 1);
	localparam logic [cnt_w-1:0] cnt_full = cnt_w'(stack_depth);

	logic push_q;
	logic pop_q;
	logic [cnt_w-1:0] cnt_q;
	logic [cnt_w-1:0] cnt_d;
	// Overflow, full, empty
	logic [2:0] sticky_q;
	logic [2:0] sticky_d;
	logic [idx_w-1:0] top_idx;
	logic [data_w-1:0] pcstk_mem [stack_depth];
	logic mode1_q;
	logic [astat_w-1:0] astat_q;
	logic wr_hit;
	logic [data_w-1:0] rd_mux;

	// Status layout is {ss, sz, sv, mv, mn, as, ac, an, av, az}, sign bits dropped
	assign flags = {status[8:5], status[3:0]};

	// Next pointer and sticky state
	always_comb begin
		cnt_d = cnt_q;
		if (pop_q && !sticky_q[0]) begin
			cnt_d = cnt_q - 1'b1;
		end else if (push_q && !sticky_q[1]) begin
			cnt_d = cnt_q + 1'b1;
		end
		sticky_d[0] = (cnt_d == '0);
		sticky_d[1] = (cnt_d == cnt_full);
		sticky_d[2] = sticky_q[2] || (push_q && sticky_q[1]);
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			push_q <= 1'b0;
			pop_q <= 1'b0;
			cnt_q <= '0;
			sticky_q <= 3'b001;
		end else begin
			push_q <= push;
			pop_q <= pop;
			cnt_q <= cnt_d;
			sticky_q <= sticky_d;
		end
	end

	assign top_idx = (cnt_q == '0) ? '0 : idx_w'(cnt_q - 1'b1);

	always_ff @(posedge clk) begin
		if (seq_wen && (seq_wr_addr == sr_pcstk)) begin
			pcstk_mem[top_idx] <= bc_data;
		end
	end

	// MODE1 and ASTAT, ASTAT tracks the flags unless written
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			mode1_q <= 1'b0;
			astat_q <= '0;
		end else begin
			if (seq_wen && (seq_wr_addr == sr_mode1)) begin
				mode1_q <= bc_data[0];
			end
			if (seq_wen && (seq_wr_addr == sr_astat)) begin
				astat_q <= bc_data[astat_w-1:0];
			end else begin
				astat_q <= status;
			end
		end
	end

	// Pointer and sticky read their next values
	always_comb begin
		case (seq_rd_addr)
			sr_faddr:  rd_mux = faddr_q;
			sr_daddr:  rd_mux = daddr_q;
			sr_pc:     rd_mux = pc_q;
			sr_pcstk:  rd_mux = pcstk_mem[top_idx];
			sr_pcstkp: rd_mux = data_w'(cnt_d);
			sr_mode1:  rd_mux = data_w'(mode1_q);
			sr_astat:  rd_mux = data_w'(astat_q);
			sr_sticky: rd_mux = data_w'(sticky_d);
			default:   rd_mux = '0;
		endcase
	end

	assign wr_hit = seq_wen && (seq_wr_addr == seq_rd_addr) &&
		(seq_rd_addr inside {sr_pcstk, sr_mode1, sr_astat});
	assign seq_rd_data = wr_hit ? bc_data : rd_mux;

endmodule

/* hdl/cond_eval.sv */
// Condition code evaluation
`timescale 1ns/1ps

module cond_eval (
	input  logic                         cond_en,
	input  logic [seq_pkg::cc_w-1:0]     cond_code,
	input  logic [seq_pkg::flag_w-1:0]   flags,
	output logic                         cond_true
);
	import seq_pkg::*;

	localparam int sel_w = $clog2(flag_w);

	logic sel_flag;

	assign sel_flag = flags[cond_code[sel_w-1:0]];

	always_comb begin
		if (!cond_en) begin
			cond_true = 1'b1;
		end else if (cond_code[cc_w-1]) begin
			// Codes 16 and up
			cond_true = 1'b1;
		end else if (cond_code[sel_w]) begin
			cond_true = !sel_flag;
		end else begin
			cond_true = sel_flag;
		end
	end

endmodule

/* hdl/compute_decode.sv */
// Compute field decode
`timescale 1ns/1ps

module compute_decode (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            cu_en,
	input  logic [seq_pkg::cu_w-1:0]        cu_field,
	output logic                            alu_en,
	output logic                            mul_en,
	output logic                            shf_en,
	output logic [5:0]                      cu_func,
	output logic [seq_pkg::rf_addr_w-1:0]   cu_raddr_x,
	output logic [seq_pkg::rf_addr_w-1:0]   rf_raddr_y,
	output logic [seq_pkg::rf_addr_w-1:0]   cu_waddr
);
	import seq_pkg::*;

	// Unit, function, rn, rx, ry from the top, lowest bit spare
	localparam int unit_lo = cu_w - 2;
	localparam int func_lo = unit_lo - 6;
	localparam int rn_lo = func_lo - rf_addr_w;
	localparam int rx_lo = rn_lo - rf_addr_w;
	localparam int ry_lo = rx_lo - rf_addr_w;

	logic [1:0] unit;

	assign unit = cu_field[unit_lo +: 2];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			alu_en <= 1'b0;
			mul_en <= 1'b0;
			shf_en <= 1'b0;
			cu_func <= '0;
			cu_waddr <= '0;
		end else begin
			alu_en <= cu_en && (unit == 2'b00);
			mul_en <= cu_en && (unit == 2'b01);
			shf_en <= cu_en && (unit == 2'b10);
			if (cu_en) begin
				cu_func <= cu_field[func_lo +: 6];
				cu_waddr <= cu_field[rn_lo +: rf_addr_w];
			end
		end
	end

	// Operand reads happen in the decode cycle
	assign cu_raddr_x = cu_field[rx_lo +: rf_addr_w];
	assign rf_raddr_y = cu_field[ry_lo +: rf_addr_w];

endmodule

/* hdl/ureg_decode.sv */
// Universal register address decode
`timescale 1ns/1ps

module ureg_decode (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              push,
	input  logic                              pop,
	input  logic                              imm_inst,
	input  logic                              dm_inst,
	input  logic                              utrans_inst,
	input  logic                              dm_wrb,
	input  logic [seq_pkg::ureg_w-1:0]        ureg_dst,
	input  logic [seq_pkg::ureg_w-1:0]        ureg_src,
	output logic [seq_pkg::rf_addr_w-1:0]     xfer_raddr,
	output logic [seq_pkg::rf_addr_w-1:0]     xfer_waddr,
	output logic                              rf_wen,
	output logic [seq_pkg::sreg_addr_w-1:0]   dag_rd_addr,
	output logic [seq_pkg::sreg_addr_w-1:0]   dag_wr_addr,
	output logic                              dag_wen,
	output logic [seq_pkg::sreg_addr_w-1:0]   seq_rd_addr,
	output logic [seq_pkg::sreg_addr_w-1:0]   seq_wr_addr,
	output logic                              seq_wen,
	output logic [1:0]                        bc_src_sel,
	output logic [1:0]                        bc_dst_sel
);
	import seq_pkg::*;

	logic [ureg_w-1:0] rd_ureg;
	logic [2:0] rd_grp;
	logic [2:0] wr_grp;
	logic wr_valid;

	function automatic logic [1:0] bus_sel(input logic [2:0] grp);
		case (grp)
			grp_dag: return 2'd1;
			grp_seq: return 2'd2;
			default: return 2'd0;
		endcase
	endfunction

	// A DM write reads the ureg named in the destination field
	assign rd_ureg = utrans_inst ? ureg_src : ureg_dst;
	assign rd_grp = rd_ureg[ureg_w-1 -: 3];
	assign wr_grp = ureg_dst[ureg_w-1 -: 3];
	assign wr_valid = utrans_inst || imm_inst || (dm_inst && !dm_wrb);

	assign xfer_raddr = rd_ureg[rf_addr_w-1:0];
	assign xfer_waddr = ureg_dst[rf_addr_w-1:0];
	assign dag_rd_addr = rd_ureg[sreg_addr_w-1:0];
	assign seq_rd_addr = rd_ureg[sreg_addr_w-1:0];

	// Writes land when the bus connect presents the data
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rf_wen <= 1'b0;
			dag_wen <= 1'b0;
			seq_wen <= 1'b0;
			dag_wr_addr <= '0;
			seq_wr_addr <= '0;
		end else begin
			rf_wen <= wr_valid && (wr_grp == grp_rf);
			dag_wen <= wr_valid && (wr_grp == grp_dag);
			seq_wen <= wr_valid && (wr_grp == grp_seq);
			dag_wr_addr <= ureg_dst[sreg_addr_w-1:0];
			seq_wr_addr <= ureg_dst[sreg_addr_w-1:0];
		end
	end

	always_comb begin
		if (push || pop) begin
			// Stack moves stay inside the sequencer
			bc_src_sel = 2'd2;
			bc_dst_sel = 2'd2;
		end else begin
			bc_src_sel = (imm_inst || (dm_inst && !dm_wrb)) ? 2'd3 : bus_sel(rd_grp);
			bc_dst_sel = (dm_inst && dm_wrb) ? 2'd3 : bus_sel(wr_grp);
		end
	end

endmodule

/* hdl/prog_seq_top.sv */
// Program sequencer top level
`timescale 1ns/1ps

module prog_seq_top #(
	parameter int stack_depth = 2,
	parameter logic [seq_pkg::data_w-1:0] reset_addr = '0
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              interrupt,
	input  logic [seq_pkg::inst_w-1:0]        inst,
	input  logic [seq_pkg::astat_w-1:0]       status,
	input  logic [seq_pkg::data_w-1:0]        bc_data,
	output logic [seq_pkg::data_w-1:0]        pm_addr,
	output logic                              pm_cs,
	output logic                              dm_cs,
	output logic                              dm_wrb,
	output logic                              dag_en,
	output logic                              dag_modify,
	output logic [2:0]                        dag_isel,
	output logic [2:0]                        dag_msel,
	output logic [seq_pkg::data_w-1:0]        imm_data,
	output logic [seq_pkg::rf_addr_w-1:0]     rf_raddr_x,
	output logic [seq_pkg::rf_addr_w-1:0]     rf_raddr_y,
	output logic [seq_pkg::rf_addr_w-1:0]     rf_waddr,
	output logic                              rf_wen,
	output logic                              alu_en,
	output logic                              mul_en,
	output logic                              shf_en,
	output logic [5:0]                        cu_func,
	output logic [seq_pkg::sreg_addr_w-1:0]   dag_rd_addr,
	output logic [seq_pkg::sreg_addr_w-1:0]   dag_wr_addr,
	output logic                              dag_wen,
	output logic [1:0]                        bc_src_sel,
	output logic [1:0]                        bc_dst_sel,
	output logic [seq_pkg::data_w-1:0]        seq_rd_data
);
	import seq_pkg::*;

	logic cond_en;
	logic [cc_w-1:0] cond_code;
	logic cond_true;
	logic [flag_w-1:0] flags;
	logic cu_en;
	logic [cu_w-1:0] cu_field;
	logic [rf_addr_w-1:0] cu_raddr_x;
	logic [rf_addr_w-1:0] cu_waddr;
	logic [rf_addr_w-1:0] xfer_raddr;
	logic [rf_addr_w-1:0] xfer_waddr;
	logic push;
	logic pop;
	logic imm_inst;
	logic dm_inst;
	logic utrans_inst;
	logic [ureg_w-1:0] ureg_dst;
	logic [ureg_w-1:0] ureg_src;
	logic [data_w-1:0] faddr_q;
	logic [data_w-1:0] daddr_q;
	logic [data_w-1:0] pc_q;
	logic [sreg_addr_w-1:0] seq_rd_addr;
	logic [sreg_addr_w-1:0] seq_wr_addr;
	logic seq_wen;

	// Port names match the nets one to one
	seq_ctrl #(
		.reset_addr(reset_addr)
	) seq_ctrl_i (.*);

	cond_eval cond_eval_i (.*);

	compute_decode compute_decode_i (.*);

	ureg_decode ureg_decode_i (.*);

	seq_regs #(
		.stack_depth(stack_depth)
	) seq_regs_i (.*);

endmodule

/* test/tb_prog_seq.sv */
// Program sequencer testbench
`timescale 1ns/1ps

module tb_prog_seq;
	import seq_pkg::*;

	localparam int stack_depth = 2;
	localparam logic [data_w-1:0] reset_addr = 16'h0100;
	localparam int max_rows = 80;
	localparam logic [inst_w-1:0] nop_word = 32'h0000_0000;
	localparam logic [inst_w-1:0] idle_word = 32'h0080_0000;
	localparam logic [inst_w-1:0] push_word = 32'h0200_0000;
	localparam logic [inst_w-1:0] pop_word = 32'h0300_0000;

	logic clk;
	logic rst;
	logic interrupt;
	logic [inst_w-1:0] inst;
	logic [astat_w-1:0] status;
	logic [data_w-1:0] bc_data;
	logic [data_w-1:0] pm_addr;
	logic pm_cs;
	logic dm_cs;
	logic dm_wrb;
	logic dag_en;
	logic dag_modify;
	logic [2:0] dag_isel;
	logic [2:0] dag_msel;
	logic [data_w-1:0] imm_data;
	logic [rf_addr_w-1:0] rf_raddr_x;
	logic [rf_addr_w-1:0] rf_raddr_y;
	logic [rf_addr_w-1:0] rf_waddr;
	logic rf_wen;
	logic alu_en;
	logic mul_en;
	logic shf_en;
	logic [5:0] cu_func;
	logic [sreg_addr_w-1:0] dag_rd_addr;
	logic [sreg_addr_w-1:0] dag_wr_addr;
	logic dag_wen;
	logic [1:0] bc_src_sel;
	logic [1:0] bc_dst_sel;
	logic [data_w-1:0] seq_rd_data;

	// Stimulus columns
	logic [inst_w-1:0] t_inst [max_rows];
	logic [astat_w-1:0] t_status [max_rows];
	logic [data_w-1:0] t_bc [max_rows];
	logic t_irq [max_rows];
	logic t_chk_rd [max_rows];
	// Expected columns
	logic [data_w-1:0] e_pm_addr [max_rows];
	logic e_pm_cs [max_rows];
	logic e_dm_cs [max_rows];
	logic e_dm_wrb [max_rows];
	logic [2:0] e_units [max_rows];
	logic e_chk_cu [max_rows];
	logic [5:0] e_func [max_rows];
	logic [3:0] e_waddr [max_rows];
	logic [3:0] e_raddr_x [max_rows];
	logic [3:0] e_raddr_y [max_rows];
	logic [data_w-1:0] e_rd [max_rows];
	logic [data_w-1:0] e_imm [max_rows];
	// DAG enable, modify, index and modifier select
	logic [7:0] e_dag [max_rows];
	logic [1:0] e_wens [max_rows];
	logic [4:0] e_dag_wr [max_rows];
	logic [4:0] e_dag_rd [max_rows];
	logic [3:0] e_bc [max_rows];

	int n_rows;
	integer seed = 13;
	int cycles;
	int limit = 1000;
	int errors;

	prog_seq_top #(
		.stack_depth(stack_depth),
		.reset_addr(reset_addr)
	) prog_seq_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s got 'h%0h, expected 'h%0h", $time, what, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	function automatic logic [inst_w-1:0] xfer_word(input logic [7:0] dst, input logic [7:0] src);
		return {2'b00, 6'b000100, dst, src, 8'h00};
	endfunction

	// Bus connect code of a ureg group
	function automatic logic [1:0] grp_to_sel(input logic [2:0] grp);
		if (grp == 3'd1) begin
			return 2'd1;
		end else if (grp == 3'd2) begin
			return 2'd2;
		end
		return 2'd0;
	endfunction

	task automatic add_row(input logic [inst_w-1:0] word, input logic irq, input logic chk_rd);
		t_inst[n_rows] = word;
		t_status[n_rows] = astat_w'($random(seed));
		t_bc[n_rows] = data_w'($random(seed));
		t_irq[n_rows] = irq;
		t_chk_rd[n_rows] = chk_rd;
		n_rows++;
	endtask

	task automatic build_table();
		logic [31:0] r;
		logic [4:0] code;
		n_rows = 0;
		// Free running fetch
		repeat (4) add_row(nop_word, 1'b0, 1'b0);
		// Sticky reads at 0x5e, stack filled past full then one pop
		add_row(xfer_word(8'h00, 8'h5e), 1'b0, 1'b1);
		repeat (3) begin
			add_row(push_word, 1'b0, 1'b0);
			add_row(xfer_word(8'h00, 8'h5e), 1'b0, 1'b1);
		end
		add_row(pop_word, 1'b0, 1'b0);
		add_row(xfer_word(8'h00, 8'h5e), 1'b0, 1'b1);
		// Idle with a push that has to be ignored, then wake
		add_row(idle_word, 1'b0, 1'b0);
		add_row(push_word, 1'b0, 1'b0);
		add_row(nop_word, 1'b0, 1'b0);
		add_row(nop_word, 1'b1, 1'b0);
		add_row(nop_word, 1'b0, 1'b0);
		add_row(nop_word, 1'b0, 1'b0);
		add_row(xfer_word(8'h00, 8'h5e), 1'b0, 1'b1);
		// DM transfers over all code groups, last one unconditional
		for (int i = 0; i < 20; i++) begin
			r = $random(seed);
			code = (i < 16) ? 5'(i) : {1'b1, r[3:0]};
			add_row({i != 19, 1'b0, 6'b100100, 8'h00, r[15:5], code}, 1'b0, 1'b0);
		end
		// Compute words on every unit, mixed with register transfers
		for (int i = 0; i < 6; i++) begin
			r = $random(seed);
			add_row({i >= 4, 1'b1, 4'h0, 2'(i % 4), r[23:5], r[4:0]}, 1'b0, 1'b0);
			if (i % 2 == 1) begin
				add_row(xfer_word(8'h00, {4'h0, r[27:24]}), 1'b0, 1'b0);
			end
		end
		add_row(nop_word, 1'b0, 1'b0);
		// Immediates into the register file and a DAG register
		r = $random(seed);
		add_row({2'b00, 6'b001100, 8'h07, r[15:0]}, 1'b0, 1'b0);
		add_row({2'b00, 6'b001100, 8'h23, r[31:16]}, 1'b0, 1'b0);
		add_row(nop_word, 1'b0, 1'b0);
		add_row(xfer_word(8'h04, 8'h25), 1'b0, 1'b0);
		add_row(nop_word, 1'b0, 1'b0);
		// MODE1 at 0x5b and ASTAT at 0x5c, written then read back
		add_row(xfer_word(8'h5b, 8'h01), 1'b0, 1'b0);
		add_row(xfer_word(8'h00, 8'h5b), 1'b0, 1'b1);
		add_row(xfer_word(8'h00, 8'h5b), 1'b0, 1'b1);
		add_row(xfer_word(8'h5c, 8'h02), 1'b0, 1'b0);
		repeat (3) add_row(xfer_word(8'h00, 8'h5c), 1'b0, 1'b1);
	endtask

	// Reference model, one pass over the table
	task automatic compute_expected();
		logic idle_m;
		logic [data_w-1:0] pa;
		int cnt;
		logic ovf;
		logic mode1_m;
		logic [astat_w-1:0] astat_m;
		logic [data_w-1:0] imm_m;
		logic wen_p;
		logic [4:0] waddr_p;
		logic prev_wv;
		logic [2:0] prev_grp;
		logic [3:0] prev_dst;
		logic prev_cu;
		logic [1:0] prev_unit;
		logic [5:0] prev_func;
		logic [3:0] prev_rn;
		logic [inst_w-1:0] w;
		logic [7:0] fl;
		logic [4:0] code;
		logic [4:0] ra;
		logic [2:0] ra_grp;
		logic cond;
		logic run;
		logic cu;
		logic nc;
		logic dm;
		logic ut;
		logic im;
		logic pu;
		logic po;
		logic wv;
		idle_m = 1'b0;
		// Row 0 is loaded on the edge that also advances the fetch address
		pa = reset_addr + 1'b1;
		cnt = 0;
		ovf = 1'b0;
		mode1_m = 1'b0;
		astat_m = '0;
		imm_m = '0;
		wen_p = 1'b0;
		waddr_p = '0;
		prev_wv = 1'b0;
		prev_grp = '0;
		prev_dst = '0;
		prev_cu = 1'b0;
		prev_unit = '0;
		prev_func = '0;
		prev_rn = '0;
		for (int k = 0; k < n_rows; k++) begin
			w = t_inst[k];
			// ASTAT minus the two sign bits
			fl = {t_status[k][8:5], t_status[k][3:0]};
			code = w[4:0];
			if (!w[31] || code[4]) begin
				cond = 1'b1;
			end else if (code[3]) begin
				cond = !fl[code[2:0]];
			end else begin
				cond = fl[code[2:0]];
			end
			run = cond && !idle_m;
			cu = run && w[30];
			nc = run && !w[30];
			dm = nc && (w[29:26] == 4'b1001);
			ut = nc && (w[29:26] == 4'b0001);
			im = nc && (w[29:26] == 4'b0011);
			pu = nc && (w[29:24] == 6'b000010);
			po = nc && (w[29:24] == 6'b000011);
			wv = ut || im || (dm && !w[6]);

			e_pm_addr[k] = pa;
			e_pm_cs[k] = !idle_m;
			e_dm_cs[k] = dm;
			e_dm_wrb[k] = w[6];
			e_chk_cu[k] = prev_cu;
			e_units[k] = 3'b000;
			if (prev_cu && prev_unit != 2'd3) begin
				e_units[k] = 3'b100 >> prev_unit;
			end
			e_func[k] = prev_func;
			e_waddr[k] = prev_cu ? prev_rn : prev_dst;
			if (cu) begin
				e_raddr_x[k] = w[13:10];
			end else if (ut) begin
				e_raddr_x[k] = w[11:8];
			end else begin
				e_raddr_x[k] = w[19:16];
			end
			e_raddr_y[k] = w[9:6];
			e_imm[k] = im ? w[15:0] : imm_m;
			e_dag[k] = {dm, w[28], w[12:10], w[9:7]};
			e_wens[k] = {prev_wv && prev_grp == 3'd0, prev_wv && prev_grp == 3'd1};
			e_dag_wr[k] = waddr_p;

			// Readback, pending bus connect write wins
			ra = ut ? w[12:8] : w[20:16];
			ra_grp = ut ? w[15:13] : w[23:21];
			e_dag_rd[k] = ra;
			if (pu || po) begin
				e_bc[k] = 4'b1010;
			end else begin
				e_bc[k][3:2] = (im || (dm && !w[6])) ? 2'd3 : grp_to_sel(ra_grp);
				e_bc[k][1:0] = (dm && w[6]) ? 2'd3 : grp_to_sel(w[23:21]);
			end
			if (wen_p && ra == waddr_p && (ra == sr_pcstk || ra == sr_mode1 || ra == sr_astat)) begin
				e_rd[k] = t_bc[k];
			end else begin
				case (ra)
					sr_mode1:  e_rd[k] = {15'd0, mode1_m};
					sr_astat:  e_rd[k] = {6'd0, astat_m};
					sr_sticky: e_rd[k] = {13'd0, ovf, cnt == stack_depth, cnt == 0};
					default:   e_rd[k] = '0;
				endcase
			end

			// State after the next edge
			if (!idle_m) begin
				pa = pa + 1'b1;
			end
			if (idle_m) begin
				idle_m = !t_irq[k];
			end else begin
				idle_m = (w[31:23] == 9'd1);
			end
			if (pu) begin
				if (cnt == stack_depth) begin
					ovf = 1'b1;
				end else begin
					cnt++;
				end
			end
			if (po && cnt > 0) begin
				cnt--;
			end
			if (wen_p && waddr_p == sr_mode1) begin
				mode1_m = t_bc[k][0];
			end
			astat_m = (wen_p && waddr_p == sr_astat) ? t_bc[k][astat_w-1:0] : t_status[k];
			if (im) begin
				imm_m = w[15:0];
			end
			wen_p = wv && (w[23:21] == 3'd2);
			waddr_p = w[20:16];
			prev_wv = wv;
			prev_grp = w[23:21];
			prev_dst = w[19:16];
			prev_cu = cu;
			prev_unit = w[25:24];
			prev_func = w[23:18];
			prev_rn = w[17:14];
		end
	endtask

	task automatic check_row(input int k);
		string tag;
		tag = $sformatf("row %0d", k);
		check_value({tag, " pm_addr"}, pm_addr, e_pm_addr[k]);
		check_value({tag, " pm_cs"}, pm_cs, e_pm_cs[k]);
		check_value({tag, " dm_cs"}, dm_cs, e_dm_cs[k]);
		check_value({tag, " dm_wrb"}, dm_wrb, e_dm_wrb[k]);
		check_value({tag, " unit strobes"}, {alu_en, mul_en, shf_en}, e_units[k]);
		check_value({tag, " rf_raddr_x"}, rf_raddr_x, e_raddr_x[k]);
		check_value({tag, " rf_raddr_y"}, rf_raddr_y, e_raddr_y[k]);
		check_value({tag, " rf_waddr"}, rf_waddr, e_waddr[k]);
		check_value({tag, " imm_data"}, imm_data, e_imm[k]);
		check_value({tag, " dag controls"}, {dag_en, dag_modify, dag_isel, dag_msel},
			e_dag[k]);
		check_value({tag, " write enables"}, {rf_wen, dag_wen}, e_wens[k]);
		check_value({tag, " dag_wr_addr"}, dag_wr_addr, e_dag_wr[k]);
		check_value({tag, " dag_rd_addr"}, dag_rd_addr, e_dag_rd[k]);
		check_value({tag, " bus selects"}, {bc_src_sel, bc_dst_sel}, e_bc[k]);
		if (e_chk_cu[k]) begin
			check_value({tag, " cu_func"}, cu_func, e_func[k]);
		end
		if (t_chk_rd[k]) begin
			check_value({tag, " seq_rd_data"}, seq_rd_data, e_rd[k]);
		end
	endtask

	initial begin
		rst = 1'b0;
		interrupt = 1'b0;
		inst = '0;
		status = '0;
		bc_data = '0;
		errors = 0;
		build_table();
		compute_expected();
		limit = 2 * n_rows + 10;

		repeat (10) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		check_value("reset pm_addr", pm_addr, reset_addr);
		check_value("reset pm_cs", pm_cs, 1'b1);
		check_value("reset dm_cs", dm_cs, 1'b0);
		check_value("reset unit strobes", {alu_en, mul_en, shf_en}, 3'b000);
		check_value("reset enables", {rf_wen, dag_wen, dag_en}, 3'b000);

		for (int i = 0; i < n_rows; i++) begin
			@(posedge clk);
			inst <= t_inst[i];
			status <= t_status[i];
			bc_data <= t_bc[i];
			interrupt <= t_irq[i];
			@(negedge clk);
			check_row(i);
		end

		if (errors == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("Simulation FAILED");
			$fatal(1, "%0d checks failed", errors);
		end
	end

	// Watchdog
	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > limit) begin
				$display("Timeout: table not finished after %0d cycles", limit);
				$display("Simulation FAILED");
				$fatal(1, "Cycle limit reached");
			end
		end
	end

endmodule

/* build.f */
common/seq_pkg.sv
sequencer/seq_ctrl.sv
sequencer/seq_regs.sv
hdl/cond_eval.sv
hdl/compute_decode.sv
hdl/ureg_decode.sv
hdl/prog_seq_top.sv
test/tb_prog_seq.sv

/* Makefile */
# Program sequencer simulation with Verilator

VERILATOR ?= verilator
TOP ?= tb_prog_seq
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
